/* bench/corr_checker.sv */
`timescale 1ns/1ps
`include "corr_cfg.svh"

// Watches the host readback port against the trace values
module corr_checker (
   input  logic                            sram_ck_i,
   input  logic                            rst_n_i,
   input  logic                            en_i,
   input  logic                            sw_i,
   input  logic [`CORR_IBITS-1:0]          re_i,
   input  logic [`CORR_IBITS-1:0]          im_i,
   input  logic                            sram_ce_i,
   input  logic [corr_bus_pkg::ADDR_W-1:0] sram_ad_i,
   input  logic [`CORR_ACCUM-1:0]          sram_do_i,   // DUT sram_do_o
   input  logic [`CORR_ACCUM-1:0]          exp_i,       // Expected data, valid with sram_ce_i
   output int                              n_chk_o,
   output int                              n_err_o,
   output int                              n_pend_o
);

   corr_bus_pkg::rd_addr_u  ad_q [$];    // Reads in flight, oldest first
   logic [`CORR_ACCUM-1:0]  exp_q [$];
   logic [1:0]              rd_pipe;     // Read seen one and two cycles ago
   logic [`CORR_ACCUM-1:0]  hold_val;    // Output expected between reads

   // ------------------------------------------------------------
   // Compare on the falling edge, where everything is settled
   // ------------------------------------------------------------
   always @(negedge sram_ck_i) begin
      corr_bus_pkg::rd_addr_u ad_v;
      logic [`CORR_ACCUM-1:0] exp_v;
      if (!rst_n_i) begin
         rd_pipe  = 2'b00;
         hold_val = '0;   // Output starts at zero
         n_chk_o  = 0;
         n_err_o  = 0;
         ad_q.delete();
         exp_q.delete();
      end else begin
         if (rd_pipe[1]) begin
            ad_v  = ad_q.pop_front();   // Data due two cycles after the read
            exp_v = exp_q.pop_front();
            n_chk_o++;
            if (sram_do_i !== exp_v) begin
               n_err_o++;
               $display("MISMATCH at %0.1f ns: sram_do_o address %h expected %h actual %h",
                        $realtime, ad_v.flat, exp_v, sram_do_i);
            end
            hold_val = sram_do_i;
         end else if (sram_do_i !== hold_val) begin
            n_err_o++;   // Early data or lost hold
            $display("MISMATCH at %0.1f ns: sram_do_o changed without a read, expected %h actual %h",
                     $realtime, hold_val, sram_do_i);
            hold_val = sram_do_i;
         end
         rd_pipe = {rd_pipe[0], sram_ce_i};
         if (sram_ce_i) begin
            ad_v.flat = sram_ad_i;
            ad_q.push_back(ad_v);
            exp_q.push_back(exp_i);
         end
      end
      n_pend_o = exp_q.size();
   end

endmodule

/* bench/corr_trace.txt */
# S re im gap (hex sample, decimal cycles to next) | W switch | R addr expected (hex)
# T name starts a test; addr is {bank, slot, lane, part}
T reset
R 000 0
R 05f 0
T single
S 000fff 000000 16
R 000 1
R 003 0
R 05b 1
R 01c 2
R 05d 1
R 04e 1
R 017 0
T accumulate
S 000000 000000 16
S ffffff 000000 16
R 000 5
R 003 2
R 01d 4
R 04e 5
T switch
W
S 000001 000000 16
R 080 1
R 089 2
R 0dd 1
R 0b6 2
R 001 3
R 05c 5
T repeat
R 016 6
R 016 6
R 0b7 2
R 0b7 2
T min_gap
S 000000 000000 12
S ffffff 000000 12
S 000000 000000 16
R 080 7
R 089 6
R 0dd 5
R 0b6 8

/* bench/tb_corr_block.sv */
`timescale 1ns/1ps
`include "corr_cfg.svh"

// Trace-driven testbench for the correlator block
module tb_corr_block;

   logic                            sram_ck_i = 1'b0;
   logic                            rst_n_i;
   logic                            en_i;
   logic                            sw_i;
   logic [`CORR_IBITS-1:0]          re_i;
   logic [`CORR_IBITS-1:0]          im_i;
   logic                            sram_ce_i;
   logic [corr_bus_pkg::ADDR_W-1:0] sram_ad_i;
   logic [`CORR_ACCUM-1:0]          sram_do_o;
   logic [`CORR_ACCUM-1:0]          exp_dat;   // Expected data of the read being issued

   int    n_chk;           // Reads compared by the checker
   int    n_err;           // Checker errors
   int    n_pend;          // Reads still in flight
   int    tb_err  = 0;     // Trace problems
   int    n_lines = 0;
   int    n_tests = 0;
   int    t_chk0  = 0;     // Counts at the start of a test
   int    t_err0  = 0;
   bit    trace_ok = 1'b0;
   bit    done     = 1'b0;
   string t_name   = "";
   string lines [$];       // Whole trace, one entry per line

   always #2 sram_ck_i = ~sram_ck_i;   // 4 ns period

   corr_block i_dut (
      .sram_ck_i (sram_ck_i),
      .rst_n_i   (rst_n_i),
      .en_i      (en_i),
      .sw_i      (sw_i),
      .re_i      (re_i),
      .im_i      (im_i),
      .sram_ce_i (sram_ce_i),
      .sram_ad_i (sram_ad_i),
      .sram_do_o (sram_do_o)
   );

   corr_checker i_chk (
      .sram_ck_i (sram_ck_i),
      .rst_n_i   (rst_n_i),
      .en_i      (en_i),
      .sw_i      (sw_i),
      .re_i      (re_i),
      .im_i      (im_i),
      .sram_ce_i (sram_ce_i),
      .sram_ad_i (sram_ad_i),
      .sram_do_i (sram_do_o),
      .exp_i     (exp_dat),
      .n_chk_o   (n_chk),
      .n_err_o   (n_err),
      .n_pend_o  (n_pend)
   );

   // ------------------------------------------------------------
   // Driver tasks, inputs change 0.5 ns after the edge
   // ------------------------------------------------------------
   task automatic next_cycle();
      @(posedge sram_ck_i);
      #0.5;
   endtask

   task automatic load_trace();
      int    fd;
      string ln;
      fd = $fopen("bench/corr_trace.txt", "r");
      if (fd != 0) begin
         while (!$feof(fd)) begin
            if ($fgets(ln, fd) > 0) lines.push_back(ln);
         end
         $fclose(fd);
         trace_ok = 1'b1;
      end
      n_lines = lines.size();
   endtask

   task automatic drive_sample(input logic [`CORR_IBITS-1:0] re,
                               input logic [`CORR_IBITS-1:0] im, input int gap);
      en_i = 1'b1;
      re_i = re;
      im_i = im;
      next_cycle();
      en_i = 1'b0;
      repeat (gap - 1) next_cycle();   // Next command lands gap cycles later
   endtask

   task automatic drive_switch();
      sw_i = 1'b1;
      next_cycle();
      sw_i = 1'b0;
   endtask

   task automatic drive_read(input logic [corr_bus_pkg::ADDR_W-1:0] ad,
                             input logic [`CORR_ACCUM-1:0] expv);
      sram_ce_i = 1'b1;
      sram_ad_i = ad;
      exp_dat   = expv;   // Picked up by the checker with the read
      next_cycle();
      sram_ce_i = 1'b0;
   endtask

   // Drain reads, then report the test that just ended
   task automatic close_test();
      while (n_pend != 0) next_cycle();
      if (t_name != "") begin
         n_tests++;
         $display("test %-10s reads %0d errors %0d %s", t_name, n_chk - t_chk0,
                  n_err - t_err0, (n_err == t_err0) ? "pass" : "fail");
      end
      t_chk0 = n_chk;
      t_err0 = n_err;
   endtask

   task automatic run_trace();
      string       cmd;
      string       arg;
      logic [31:0] a;
      logic [31:0] b;
      int          gap;
      foreach (lines[i]) begin
         cmd = "";
         void'($sscanf(lines[i], "%s", cmd));
         if (cmd == "T") begin
            close_test();
            void'($sscanf(lines[i], "%s %s", cmd, arg));
            t_name = arg;
         end else if (cmd == "S") begin
            void'($sscanf(lines[i], "%s %h %h %d", cmd, a, b, gap));
            drive_sample(a[`CORR_IBITS-1:0], b[`CORR_IBITS-1:0], gap);
         end else if (cmd == "W") begin
            drive_switch();
         end else if (cmd == "R") begin
            void'($sscanf(lines[i], "%s %h %h", cmd, a, b));
            drive_read(a[corr_bus_pkg::ADDR_W-1:0], b[`CORR_ACCUM-1:0]);
         end else if (cmd != "" && cmd.substr(0, 0) != "#") begin
            tb_err++;
            $display("unknown trace command '%s' on line %0d", cmd, i + 1);
         end
      end
      close_test();
   endtask

   // ------------------------------------------------------------
   // Main sequence
   // ------------------------------------------------------------
   initial begin : stimulus
      rst_n_i   = 1'b0;
      en_i      = 1'b0;
      sw_i      = 1'b0;
      re_i      = '0;
      im_i      = '0;
      sram_ce_i = 1'b0;
      sram_ad_i = '0;
      exp_dat   = '0;
      load_trace();
      repeat (8) @(posedge sram_ck_i);   // Reset for 8 cycles
      #0.5;
      rst_n_i = 1'b1;
      next_cycle();
      if (!trace_ok) begin
         $display("trace file bench/corr_trace.txt could not be opened");
         $display("CHECKS FAILED");
         $finish;
      end else begin
         run_trace();
         $display("summary: tests %0d reads %0d errors %0d", n_tests, n_chk,
                  n_err + tb_err);
         if (n_err + tb_err == 0 && n_chk > 0) begin
            $display("ALL CHECKS PASSED");
         end else begin
            $display("CHECKS FAILED");
         end
         done = 1'b1;
         $finish;
      end
   end

   // Budget of 20 cycles per trace line plus 200
   initial begin : watchdog
      wait (n_lines > 0);
      repeat (20 * n_lines + 200) @(posedge sram_ck_i);
      if (!done) begin
         $display("timeout: trace did not finish within %0d cycles", 20 * n_lines + 200);
         $display("CHECKS FAILED");
         $finish;
      end
   end

endmodule

/* filelist.f */
+incdir+hw
hw/corr_pkg.sv
hw/corr_bus_pkg.sv
hw/vis_wr_if.sv
hw/pair_correlator.sv
hw/corr_engine.sv
hw/corr_block_ctrl.sv
hw/vis_bank_ram.sv
hw/corr_block.sv
bench/corr_checker.sv
bench/tb_corr_block.sv

/* hw/corr_block.sv */
`timescale 1ns/1ps
`include "corr_cfg.svh"

// Correlator block top
module corr_block (
   input  logic                              sram_ck_i,
   input  logic                              rst_n_i,
   input  logic                              en_i,        // Sample strobe
   input  logic                              sw_i,        // Bank switch
   input  logic [`CORR_IBITS-1:0]            re_i,
   input  logic [`CORR_IBITS-1:0]            im_i,
   input  logic                              sram_ce_i,   // Host read
   input  logic [corr_bus_pkg::ADDR_W-1:0]   sram_ad_i,
   output logic [`CORR_ACCUM-1:0]            sram_do_o
);

   // Controller to engine
   logic            active;
   corr_pkg::slot_t slot;
   logic            fresh;
   corr_pkg::bank_t bank;

   vis_wr_if vis_wr ();   // Engine to RAM

   // ------------------------------------------------------------
   // Instances
   // ------------------------------------------------------------
   corr_block_ctrl i_ctrl (
      .sram_ck_i (sram_ck_i),
      .rst_n_i   (rst_n_i),
      .en_i      (en_i),
      .sw_i      (sw_i),
      .active_o  (active),
      .slot_o    (slot),
      .fresh_o   (fresh),
      .bank_o    (bank)
   );

   corr_engine i_engine (
      .sram_ck_i (sram_ck_i),
      .rst_n_i   (rst_n_i),
      .en_i      (en_i),
      .re_i      (re_i),
      .im_i      (im_i),
      .active_i  (active),
      .slot_i    (slot),
      .fresh_i   (fresh),
      .bank_i    (bank),
      .wr        (vis_wr.src)
   );

   vis_bank_ram i_ram (
      .sram_ck_i (sram_ck_i),
      .rst_n_i   (rst_n_i),
      .wr        (vis_wr.dst),
      .sram_ce_i (sram_ce_i),
      .sram_ad_i (sram_ad_i),
      .sram_do_o (sram_do_o)
   );

endmodule

/* hw/corr_block_ctrl.sv */
`timescale 1ns/1ps
`include "corr_cfg.svh"

// Slot sequencer, bank register and clear flag
module corr_block_ctrl (
   input  logic            sram_ck_i,
   input  logic            rst_n_i,
   input  logic            en_i,       // Starts a sweep
   input  logic            sw_i,       // Bank switch request
   output logic            active_o,   // Slot strobe
   output corr_pkg::slot_t slot_o,
   output logic            fresh_o,    // Accumulators start from zero
   output corr_pkg::bank_t bank_o
);

   localparam corr_pkg::slot_t LAST = corr_pkg::slot_t'(`CORR_TRATE - 1);

   logic sw_pend;     // Switch waiting for next sweep
   logic sw_now;
   logic last_slot;

   assign last_slot = active_o && (slot_o == LAST);
   assign sw_now    = sw_pend || sw_i;

   // ------------------------------------------------------------
   // Slot sequencer
   // ------------------------------------------------------------
   always_ff @(posedge sram_ck_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         active_o <= 1'b0;
         slot_o   <= '0;
      end else if (en_i) begin
         active_o <= 1'b1;   // Slot 0 next cycle
         slot_o   <= '0;
      end else if (last_slot) begin
         active_o <= 1'b0;
      end else if (active_o) begin
         slot_o <= slot_o + 1'b1;
      end
   end

   // ------------------------------------------------------------
   // Bank and clear flag
   // ------------------------------------------------------------
   always_ff @(posedge sram_ck_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         bank_o  <= '0;
         sw_pend <= 1'b0;
         fresh_o <= 1'b1;   // First sweep after reset clears
      end else begin
         if (en_i && sw_now) begin
            bank_o  <= bank_o + 1'b1;   // Wraps after 16
            fresh_o <= 1'b1;
         end else if (last_slot) begin
            fresh_o <= 1'b0;   // Every slot cleared once
         end
         sw_pend <= sw_now && !en_i;
      end
   end

   // Next sample no earlier than the last slot
   a_en_gap: assert property (@(posedge sram_ck_i) disable iff (!rst_n_i)
      en_i |-> (!active_o || last_slot))
      else $error("en_i inside the first slots of a sweep");

   // Switch only between sweeps
   a_sw_idle: assert property (@(posedge sram_ck_i) disable iff (!rst_n_i)
      sw_i |-> !active_o)
      else $error("sw_i during a sweep");

endmodule

/* hw/corr_bus_pkg.sv */
package corr_bus_pkg;

   // ------------------------------------------------------------
   // Host readback port
   // ------------------------------------------------------------

   localparam int LANES  = 4;                // Correlator lanes per block
   localparam int LANE_W = $clog2(LANES);    // Lane field width

   // Read address width, bank + slot + lane + part
   localparam int ADDR_W = $bits(corr_pkg::bank_t) + $bits(corr_pkg::slot_t)
                           + LANE_W + 1;

   // Decoded read address, MSB first
   typedef struct packed {
      corr_pkg::bank_t   bank;   // Bank to read
      corr_pkg::slot_t   slot;   // Pair slot within the lane
      logic [LANE_W-1:0] lane;   // Lane select
      logic              part;   // 1 selects im
   } rd_field_t;

   // Same word, raw or split into fields
   typedef union packed {
      logic [ADDR_W-1:0] flat;   // As seen on sram_ad_i
      rd_field_t         f;      // RAM decode view
   } rd_addr_u;

endpackage

/* hw/corr_cfg.svh */
`ifndef CORR_CFG_SVH
`define CORR_CFG_SVH

`define CORR_ACCUM 24   // Accumulator width per component
`define CORR_IBITS 24   // Antenna count
`define CORR_TRATE 12   // Slots per sweep
`define CORR_TBITS 4    // Slot index width
`define CORR_XBITS 4    // Bank index width

// Pair tables, 12 entries of {ant_a, ant_b}, slot 0 in the low bits
// Lane 0 pairs antenna k with k+12
`define CORR_PAIRS0 {5'd11, 5'd23, 5'd10, 5'd22, 5'd9, 5'd21, 5'd8, 5'd20, \
   5'd7, 5'd19, 5'd6, 5'd18, 5'd5, 5'd17, 5'd4, 5'd16, \
   5'd3, 5'd15, 5'd2, 5'd14, 5'd1, 5'd13, 5'd0, 5'd12}
// Lane 1 pairs neighbours k and k+1
`define CORR_PAIRS1 {5'd11, 5'd12, 5'd10, 5'd11, 5'd9, 5'd10, 5'd8, 5'd9, \
   5'd7, 5'd8, 5'd6, 5'd7, 5'd5, 5'd6, 5'd4, 5'd5, \
   5'd3, 5'd4, 5'd2, 5'd3, 5'd1, 5'd2, 5'd0, 5'd1}
// Lane 2 pairs neighbours in the upper half, wraps to 0
`define CORR_PAIRS2 {5'd23, 5'd0, 5'd22, 5'd23, 5'd21, 5'd22, 5'd20, 5'd21, \
   5'd19, 5'd20, 5'd18, 5'd19, 5'd17, 5'd18, 5'd16, 5'd17, \
   5'd15, 5'd16, 5'd14, 5'd15, 5'd13, 5'd14, 5'd12, 5'd13}
// Lane 3 pairs antenna k with k+6
`define CORR_PAIRS3 {5'd11, 5'd17, 5'd10, 5'd16, 5'd9, 5'd15, 5'd8, 5'd14, \
   5'd7, 5'd13, 5'd6, 5'd12, 5'd5, 5'd11, 5'd4, 5'd10, \
   5'd3, 5'd9, 5'd2, 5'd8, 5'd1, 5'd7, 5'd0, 5'd6}

`endif

/* hw/corr_engine.sv */
`timescale 1ns/1ps
`include "corr_cfg.svh"

// Four correlator lanes on one captured sample
module corr_engine (
   input  logic                   sram_ck_i,
   input  logic                   rst_n_i,
   input  logic                   en_i,       // New sample strobe
   input  logic [`CORR_IBITS-1:0] re_i,
   input  logic [`CORR_IBITS-1:0] im_i,
   input  logic                   active_i,   // Slot strobe from controller
   input  corr_pkg::slot_t        slot_i,
   input  logic                   fresh_i,
   input  corr_pkg::bank_t        bank_i,
   vis_wr_if.src                  wr
);

   localparam int LANES = corr_bus_pkg::LANES;

   // Lane tables with lane 0 in the low bits
   localparam logic [LANES-1:0][`CORR_TRATE*10-1:0] LANE_PAIRS =
      {`CORR_PAIRS3, `CORR_PAIRS2, `CORR_PAIRS1, `CORR_PAIRS0};

   logic [`CORR_IBITS-1:0]          re_q;       // Sample held for the sweep
   logic [`CORR_IBITS-1:0]          im_q;
   corr_pkg::bank_t                 bank_q;     // Aligned to lane outputs
   corr_pkg::slot_t                 slot_q;
   logic [LANES-1:0]                lane_vld;
   corr_pkg::vis_t [LANES-1:0]      lane_vis;

   // ------------------------------------------------------------
   // Sample capture and write address delay
   // ------------------------------------------------------------
   always_ff @(posedge sram_ck_i) begin
      if (en_i) begin
         re_q <= re_i;
         im_q <= im_i;
      end
      bank_q <= bank_i;   // Lanes add one cycle
      slot_q <= slot_i;
   end

   // ------------------------------------------------------------
   // Lanes
   // ------------------------------------------------------------
   for (genvar g = 0; g < LANES; g++) begin : g_lane
      pair_correlator #(
         .PAIRS (LANE_PAIRS[g])
      ) i_lane (
         .sram_ck_i (sram_ck_i),
         .rst_n_i   (rst_n_i),
         .active_i  (active_i),
         .slot_i    (slot_i),
         .fresh_i   (fresh_i),
         .re_i      (re_q),
         .im_i      (im_q),
         .valid_o   (lane_vld[g]),
         .vis_o     (lane_vis[g])
      );
   end

   assign wr.we   = lane_vld[0];   // All lanes run in step
   assign wr.bank = bank_q;
   assign wr.slot = slot_q;
   assign wr.vis  = lane_vis;

endmodule

/* hw/corr_pkg.sv */
`include "corr_cfg.svh"

package corr_pkg;

   // ------------------------------------------------------------
   // Correlation data types
   // ------------------------------------------------------------

   // Complex visibility, re in the upper half
   typedef struct packed {
      logic [`CORR_ACCUM-1:0] re;   // Agreement count, real
      logic [`CORR_ACCUM-1:0] im;   // Agreement count, imaginary
   } vis_t;

   typedef logic [`CORR_TBITS-1:0] slot_t;   // Slot within a sweep
   typedef logic [`CORR_XBITS-1:0] bank_t;   // Visibility bank
   typedef logic [4:0]             ant_t;    // Antenna number, 0 to 23

   // ------------------------------------------------------------
   // Helpers
   // ------------------------------------------------------------

   // Agreements among two one-bit products, 0 to 2
   function automatic logic [1:0] agree_cnt(
      input logic x0,
      input logic y0,
      input logic x1,
      input logic y1
   );
      logic [1:0] n0;
      logic [1:0] n1;
      n0 = {1'b0, x0 ~^ y0};   // First product agrees
      n1 = {1'b0, x1 ~^ y1};   // Second product agrees
      return n0 + n1;
   endfunction

endpackage

/* hw/pair_correlator.sv */
`timescale 1ns/1ps
`include "corr_cfg.svh"

// One time-multiplexed lane, one antenna pair per cycle
module pair_correlator #(
   parameter logic [`CORR_TRATE*10-1:0] PAIRS = '0   // {a, b} per slot
) (
   input  logic                   sram_ck_i,
   input  logic                   rst_n_i,
   input  logic                   active_i,   // Slot strobe
   input  logic [`CORR_TBITS-1:0] slot_i,     // Slot being processed
   input  logic                   fresh_i,    // Start from zero
   input  logic [`CORR_IBITS-1:0] re_i,       // Captured sample, real
   input  logic [`CORR_IBITS-1:0] im_i,       // Captured sample, imag
   output logic                   valid_o,    // vis_o holds a new sum
   output corr_pkg::vis_t         vis_o
);

   localparam int AW = $bits(corr_pkg::ant_t);   // Antenna index width
   localparam int EW = 2 * AW;                   // Pair entry width

   // ------------------------------------------------------------
   // Storage
   // ------------------------------------------------------------
   corr_pkg::vis_t acc_q [`CORR_TRATE];   // One accumulator per slot

   corr_pkg::ant_t ant_a;
   corr_pkg::ant_t ant_b;
   logic           re_a;
   logic           im_a;
   logic           re_b;
   logic           im_b;
   logic [1:0]     inc_re;
   logic [1:0]     inc_im;
   corr_pkg::vis_t base;
   corr_pkg::vis_t sum;

   // ------------------------------------------------------------
   // Pair decode
   // ------------------------------------------------------------
   assign ant_a = PAIRS[int'(slot_i) * EW + AW +: AW];   // Upper half of entry
   assign ant_b = PAIRS[int'(slot_i) * EW +: AW];        // Lower half

   // Sample bits of the two antennas
   assign re_a = re_i[ant_a];
   assign im_a = im_i[ant_a];
   assign re_b = re_i[ant_b];
   assign im_b = im_i[ant_b];

   // One-bit complex product as agreement counts
   assign inc_re = corr_pkg::agree_cnt(re_a, re_b, im_a, im_b);
   assign inc_im = corr_pkg::agree_cnt(im_a, re_b, re_a, im_b);

   // ------------------------------------------------------------
   // Accumulate
   // ------------------------------------------------------------

   // Zero base on the first sweep of a bank
   assign base = fresh_i ? '0 : acc_q[slot_i];

   always_comb begin
      sum.re = base.re + `CORR_ACCUM'(inc_re);
      sum.im = base.im + `CORR_ACCUM'(inc_im);
   end

   // Write back and present the sum together
   always_ff @(posedge sram_ck_i) begin
      if (active_i) begin
         acc_q[slot_i] <= sum;
         vis_o         <= sum;   // Seen on the write port next cycle
      end
   end

   always_ff @(posedge sram_ck_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         valid_o <= 1'b0;
      end else begin
         valid_o <= active_i;   // One cycle behind the slot strobe
      end
   end

endmodule

/* hw/vis_bank_ram.sv */
`timescale 1ns/1ps
`include "corr_cfg.svh"

// Banked visibility store with host readback
module vis_bank_ram (
   input  logic                              sram_ck_i,
   input  logic                              rst_n_i,
   vis_wr_if.dst                             wr,
   input  logic                              sram_ce_i,   // Read enable
   input  logic [corr_bus_pkg::ADDR_W-1:0]   sram_ad_i,
   output logic [`CORR_ACCUM-1:0]            sram_do_o
);

   localparam int LANES = corr_bus_pkg::LANES;
   localparam int IW    = `CORR_XBITS + `CORR_TBITS;   // Word index width

   corr_pkg::vis_t [LANES-1:0] mem [2**IW];   // {bank, slot} addressed

   corr_bus_pkg::rd_addr_u                   rd_ad;
   corr_pkg::vis_t [LANES-1:0]               word_q;   // Read stage 1
   logic [corr_bus_pkg::LANE_W-1:0]          lane_q;
   logic                                     part_q;
   logic                                     rd_vld;   // Stage 2 loads
   corr_pkg::vis_t                           sel_vis;
   logic [`CORR_ACCUM-1:0]                   sel_dat;

   // ------------------------------------------------------------
   // Write port
   // ------------------------------------------------------------
   always_ff @(posedge sram_ck_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         for (int i = 0; i < 2**IW; i++) begin
            mem[i] <= '0;   // Every bank reads zero after reset
         end
      end else if (wr.we) begin
         mem[{wr.bank, wr.slot}] <= wr.vis;
      end
   end

   // ------------------------------------------------------------
   // Two-cycle read port
   // ------------------------------------------------------------
   assign rd_ad.flat = sram_ad_i;

   always_ff @(posedge sram_ck_i) begin
      if (sram_ce_i) begin
         word_q <= mem[{rd_ad.f.bank, rd_ad.f.slot}];
         lane_q <= rd_ad.f.lane;   // Kept for the 8:1 select
         part_q <= rd_ad.f.part;
      end
   end

   // 8:1 component select
   assign sel_vis = word_q[lane_q];
   assign sel_dat = part_q ? sel_vis.im : sel_vis.re;

   always_ff @(posedge sram_ck_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         rd_vld    <= 1'b0;
         sram_do_o <= '0;
      end else begin
         rd_vld <= sram_ce_i;
         if (rd_vld) begin
            sram_do_o <= sel_dat;   // Held until the next read
         end
      end
   end

   // Host reads a bank the engine has left
   a_rd_wr_clash: assert property (@(posedge sram_ck_i) disable iff (!rst_n_i)
      (sram_ce_i && wr.we) |->
         ({rd_ad.f.bank, rd_ad.f.slot} != {wr.bank, wr.slot}))
      else $error("read hits the word being written");

endmodule

/* hw/vis_wr_if.sv */
`timescale 1ns/1ps

// Visibility writes, engine to RAM
interface vis_wr_if;

   // ------------------------------------------------------------
   // Write bundle, one word per cycle while we is high
   // ------------------------------------------------------------
   logic                                      we;     // Write strobe
   corr_pkg::bank_t                           bank;   // Target bank
   corr_pkg::slot_t                           slot;   // Target slot
   corr_pkg::vis_t [corr_bus_pkg::LANES-1:0]  vis;    // One per lane

   // Engine side
   modport src (
      output we,
      output bank,
      output slot,
      output vis
   );

   // RAM side, no back-pressure
   modport dst (
      input we,
      input bank,
      input slot,
      input vis
   );

endinterface

/* run_sim.sh */
#!/bin/sh
# Build and run the correlator block testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_corr_block \
   -f filelist.f -Mdir obj_dir

./obj_dir/Vtb_corr_block > sim.log
cat sim.log

if grep -q "CHECKS FAILED" sim.log; then
   echo "simulation failed"
   exit 1
fi
echo "simulation passed"
